//--- int_core.f
+incdir+test
hw/core_pkg.sv
hw/decoder.sv
hw/register_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/writeback_stage.sv
hw/int_core.sv
test/int_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f int_core.f --top-module int_core_tb -Mdir obj_dir

output=$(./obj_dir/Vint_core_tb)
echo "$output"

if echo "$output" | grep -q "^Simulation completed successfully$"; then
  exit 0
else
  exit 1
fi

//--- test/int_core_checks.svh
`ifndef INT_CORE_CHECKS_SVH
`define INT_CORE_CHECKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic check_word(input string name, input word_t got, input word_t exp_val);
  check_count++;
  if (got !== exp_val) begin
    error_count++;
    $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp_val);
  end
endtask

task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp_val);
  check_count++;
  if (got !== exp_val) begin
    error_count++;
    $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, got, exp_val);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp_val);
  check_count++;
  if (got !== exp_val) begin
    error_count++;
    $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp_val);
  end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction encoders with fields in RV32I format order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic instr_t enc_r(input funct7_t f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                 input funct3_t f3, input reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, opcode_register};
endfunction

function automatic instr_t enc_i(input logic [11:0] imm12, input reg_addr_t rs1,
                                 input funct3_t f3, input reg_addr_t rd, input opcode_t op);
  return {imm12, rs1, f3, rd, op};
endfunction

function automatic instr_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                 input reg_addr_t rs1, input funct3_t f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcode_branch};
endfunction

function automatic instr_t enc_u(input logic [19:0] imm20, input reg_addr_t rd,
                                 input opcode_t op);
  return {imm20, rd, op};
endfunction

function automatic instr_t enc_j(input logic [20:0] off, input reg_addr_t rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, opcode_jal};
endfunction

function automatic word_t sext12(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

`endif

//--- test/int_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_core_tb
  import core_pkg::*;
();

  localparam int clock_period = 8;
  localparam int reset_cycles = 10;
  // An issued instruction occupies two clocks and at most instr_budget are issued
  localparam int instr_budget = 160;
  localparam int watchdog_ns = (reset_cycles + 2 * instr_budget + 50) * clock_period;

  logic      clock;
  logic      rst;
  logic      instr_valid;
  instr_t    instr;
  logic      retire_valid;
  logic      retire_illegal;
  logic      retire_wren;
  reg_addr_t retire_rd;
  word_t     retire_result;
  word_t     retire_pc;
  word_t     next_pc;

  word_t  ref_regs [32];
  word_t  ref_pc;
  int     error_count;
  int     check_count;
  int     test_count;
  integer seed;

  `include "int_core_checks.svh"

  int_core uut (
    .clock          (clock),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal),
    .retire_wren    (retire_wren),
    .retire_rd      (retire_rd),
    .retire_result  (retire_result),
    .retire_pc      (retire_pc),
    .next_pc        (next_pc)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before the tests finished", watchdog_ns);
    $display("Simulation failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Two's complement order follows the sign bits when they differ
  function automatic logic signed_less(input word_t x, input word_t y);
    if (x[31] != y[31]) return x[31];
    return x < y;
  endfunction

  function automatic word_t shift_right_arith(input word_t x, input logic [4:0] sh);
    word_t fill;
    fill = x[31] ? ~(32'hffffffff >> sh) : 32'h0;
    return (x >> sh) | fill;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Issue one instruction and check its retire record
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic issue(input instr_t ins, input logic exp_illegal, input logic exp_wren,
                       input reg_addr_t exp_rd, input word_t exp_result,
                       input logic cmp_result, input word_t exp_next_pc);
    int waited;
    waited = 0;
    @(posedge clock);
    #1;
    instr = ins;
    instr_valid = 1'b1;
    @(posedge clock);
    #1;
    instr_valid = 1'b0;
    instr = nop_instr;
    while (!retire_valid && waited < 4) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (!retire_valid) begin
      error_count++;
      $display("Instruction %h never retired", ins);
    end else begin
      check_bit("retire_illegal", retire_illegal, exp_illegal);
      check_bit("retire_wren", retire_wren, exp_wren);
      check_word("retire_pc", retire_pc, ref_pc);
      check_word("next_pc", next_pc, exp_next_pc);
      if (exp_wren) check_addr("retire_rd", retire_rd, exp_rd);
      if (cmp_result) check_word("retire_result", retire_result, exp_result);
      if (exp_wren) ref_regs[exp_rd] = exp_result;
      ref_pc = exp_next_pc;
    end
  endtask

  task automatic retire_write(input instr_t ins, input reg_addr_t rd, input word_t exp_val);
    issue(ins, 1'b0, 1'b1, rd, exp_val, 1'b1, ref_pc + 32'd4);
  endtask

  // Loads a full word with lui and addi
  // The upper part rounds up when the low twelve bits read as negative
  task automatic load_word(input reg_addr_t rd, input word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;
    retire_write(enc_u(upper[19:0], rd, opcode_lui), rd, {upper[19:0], 12'h000});
    retire_write(enc_i(value[11:0], rd, funct_add, rd, opcode_immediate), rd,
                 ref_regs[rd] + sext12(value[11:0]));
  endtask

  task automatic report(input string name, input int start_errors);
    test_count++;
    if (error_count == start_errors) $display("%-16s ok", name);
    else $display("%-16s FAILED with %0d errors", name, error_count - start_errors);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset();
    int start_errors;
    start_errors = error_count;
    check_bit("retire_valid", retire_valid, 1'b0);
    check_bit("retire_illegal", retire_illegal, 1'b0);
    check_bit("retire_wren", retire_wren, 1'b0);
    check_word("next_pc", next_pc, 32'h0);
    report("reset", start_errors);
  endtask

  task automatic test_load_imm();
    int start_errors;
    logic [11:0] imm12;
    logic [19:0] imm20;
    start_errors = error_count;
    imm12 = 12'($random(seed));
    retire_write(enc_i(imm12, 5'd0, funct_add, 5'd1, opcode_immediate), 5'd1, sext12(imm12));
    imm20 = 20'($random(seed));
    retire_write(enc_u(imm20, 5'd2, opcode_lui), 5'd2, {imm20, 12'h000});
    imm20 = 20'($random(seed));
    retire_write(enc_u(imm20, 5'd3, opcode_auipc), 5'd3, ref_pc + {imm20, 12'h000});
    imm12 = 12'($random(seed));
    retire_write(enc_i(imm12, 5'd1, funct_add, 5'd4, opcode_immediate), 5'd4,
                 ref_regs[1] + sext12(imm12));
    report("load immediate", start_errors);
  endtask

  task automatic test_alu_ops();
    int start_errors;
    funct3_t f3;
    funct7_t f7;
    word_t a;
    word_t b;
    word_t exp_val;
    start_errors = error_count;
    for (int i = 0; i < 10; i++) begin
      load_word(5'd5, $random(seed));
      load_word(5'd6, $random(seed));
      a = ref_regs[5];
      b = ref_regs[6];
      f7 = funct7_base;
      case (i)
        0: begin
          f3 = funct_add;
          exp_val = a + b;
        end
        1: begin
          f3 = funct_add;
          f7 = funct7_alt;
          exp_val = a - b;
        end
        2: begin
          f3 = funct_sll;
          exp_val = a << b[4:0];
        end
        3: begin
          f3 = funct_slt;
          exp_val = signed_less(a, b) ? 32'd1 : 32'd0;
        end
        4: begin
          f3 = funct_sltu;
          exp_val = (a < b) ? 32'd1 : 32'd0;
        end
        5: begin
          f3 = funct_xor;
          exp_val = a ^ b;
        end
        6: begin
          f3 = funct_srl;
          exp_val = a >> b[4:0];
        end
        7: begin
          f3 = funct_srl;
          f7 = funct7_alt;
          exp_val = shift_right_arith(a, b[4:0]);
        end
        8: begin
          f3 = funct_or;
          exp_val = a | b;
        end
        default: begin
          f3 = funct_and;
          exp_val = a & b;
        end
      endcase
      retire_write(enc_r(f7, 5'd6, 5'd5, f3, 5'd7), 5'd7, exp_val);
    end
    // The canonical nop yields zero and writes nothing
    issue(nop_instr, 1'b0, 1'b0, 5'd0, 32'h0, 1'b1, ref_pc + 32'd4);
    report("alu ops", start_errors);
  endtask

  task automatic test_zero_reg();
    int start_errors;
    start_errors = error_count;
    issue(enc_i(12'h005, 5'd1, funct_add, 5'd0, opcode_immediate),
          1'b0, 1'b0, 5'd0, 32'h0, 1'b0, ref_pc + 32'd4);
    issue(enc_r(funct7_base, 5'd2, 5'd1, funct_add, 5'd0),
          1'b0, 1'b0, 5'd0, 32'h0, 1'b0, ref_pc + 32'd4);
    issue(enc_u(20'($random(seed)), 5'd0, opcode_lui),
          1'b0, 1'b0, 5'd0, 32'h0, 1'b0, ref_pc + 32'd4);
    retire_write(enc_r(funct7_base, 5'd0, 5'd0, funct_add, 5'd8), 5'd8, 32'h0);
    retire_write(enc_i(12'hfff, 5'd0, funct_add, 5'd9, opcode_immediate), 5'd9, 32'hffffffff);
    report("register zero", start_errors);
  endtask

  task automatic test_branches();
    int start_errors;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct3_t f3;
    logic cond;
    logic [12:0] off;
    word_t a;
    word_t b;
    word_t target;
    start_errors = error_count;
    // A negative and a positive operand so signed and unsigned order disagree
    load_word(5'd10, $random(seed) | 32'h80000000);
    load_word(5'd11, ($random(seed) & 32'h7fffffff) | 32'h1);
    for (int op = 0; op < 6; op++) begin
      for (int pair = 0; pair < 3; pair++) begin
        rs1 = (pair == 1) ? 5'd11 : 5'd10;
        rs2 = (pair == 0) ? 5'd11 : 5'd10;
        a = ref_regs[rs1];
        b = ref_regs[rs2];
        case (op)
          0: begin
            f3 = funct_beq;
            cond = (a == b);
          end
          1: begin
            f3 = funct_bne;
            cond = (a != b);
          end
          2: begin
            f3 = funct_blt;
            cond = signed_less(a, b);
          end
          3: begin
            f3 = funct_bge;
            cond = !signed_less(a, b);
          end
          4: begin
            f3 = funct_bltu;
            cond = (a < b);
          end
          default: begin
            f3 = funct_bgeu;
            cond = !(a < b);
          end
        endcase
        off = (13'($random(seed)) & 13'h1ffe) | 13'h0010;
        target = cond ? ref_pc + {{19{off[12]}}, off} : ref_pc + 32'd4;
        issue(enc_b(off, rs2, rs1, f3), 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, target);
      end
    end
    report("branches", start_errors);
  endtask

  task automatic test_jumps();
    int start_errors;
    logic [20:0] joff;
    logic [11:0] jimm;
    word_t sum;
    start_errors = error_count;
    joff = 21'($random(seed)) & 21'h1ffffe;
    issue(enc_j(joff, 5'd1), 1'b0, 1'b1, 5'd1, ref_pc + 32'd4, 1'b1,
          ref_pc + {{11{joff[20]}}, joff});
    load_word(5'd5, $random(seed) | 32'h1);
    // An odd base plus an even offset gives an odd sum whose bit zero must drop
    jimm = 12'($random(seed)) & 12'hffe;
    sum = ref_regs[5] + sext12(jimm);
    issue(enc_i(jimm, 5'd5, 3'b000, 5'd2, opcode_jalr), 1'b0, 1'b1, 5'd2, ref_pc + 32'd4,
          1'b1, sum & 32'hfffffffe);
    // With rd equal to rs1 the target still uses the old value
    jimm = 12'($random(seed));
    sum = ref_regs[5] + sext12(jimm);
    issue(enc_i(jimm, 5'd5, 3'b000, 5'd5, opcode_jalr), 1'b0, 1'b1, 5'd5, ref_pc + 32'd4,
          1'b1, sum & 32'hfffffffe);
    joff = 21'($random(seed)) & 21'h1ffffe;
    issue(enc_j(joff, 5'd0), 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, ref_pc + {{11{joff[20]}}, joff});
    report("jumps", start_errors);
  endtask

  task automatic test_illegal();
    int start_errors;
    instr_t bad [8];
    start_errors = error_count;
    load_word(5'd12, $random(seed));
    bad[0] = enc_r(7'b0000001, 5'd2, 5'd1, funct_add, 5'd12);
    bad[1] = enc_r(funct7_alt, 5'd2, 5'd1, funct_xor, 5'd12);
    bad[2] = enc_i({funct7_alt, 5'd3}, 5'd1, funct_sll, 5'd12, opcode_immediate);
    bad[3] = enc_b(13'h0008, 5'd2, 5'd1, 3'b010);
    bad[4] = enc_i(12'h003, 5'd1, 3'b001, 5'd12, opcode_jalr);
    bad[5] = enc_i(12'h300, 5'd1, 3'b001, 5'd12, 7'b1110011);
    bad[6] = enc_i(12'h0ff, 5'd0, 3'b000, 5'd0, 7'b0001111);
    bad[7] = 32'h00000073;
    for (int i = 0; i < 8; i++) begin
      issue(bad[i], 1'b1, 1'b0, 5'd0, 32'h0, 1'b0, ref_pc + 32'd4);
    end
    // x12 must still hold the value loaded before
    retire_write(enc_i(12'h000, 5'd12, funct_add, 5'd13, opcode_immediate), 5'd13, ref_regs[12]);
    report("illegal", start_errors);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    seed = 32'he971;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = nop_instr;
    ref_pc = '0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (reset_cycles) @(posedge clock);
    #1;
    rst = 1'b0;

    test_reset();
    test_load_imm();
    test_alu_ops();
    test_zero_reg();
    test_branches();
    test_jumps();
    test_illegal();

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/int_core.sv
`timescale 1ns/1ps
`default_nettype none

module int_core
  import core_pkg::*;
(
  input  logic      clock,
  input  logic      rst,
  input  logic      instr_valid,
  input  instr_t    instr,
  output logic      retire_valid,
  output logic      retire_illegal,
  output logic      retire_wren,
  output reg_addr_t retire_rd,
  output word_t     retire_result,
  output word_t     retire_pc,
  output word_t     next_pc
);

  word_t     imm;
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  reg_addr_t waddr;
  logic      wren;
  logic      lui;
  logic      auipc;
  logic      jal;
  logic      jalr;
  logic      use_imm;
  alu_op_t   alu_op;
  bcu_op_t   bcu_op;
  logic      valid;

  word_t     rdata1;
  word_t     rdata2;
  word_t     alu_b;
  word_t     alu_result;
  logic      taken;
  word_t     target;
  word_t     pc;
  logic      we;
  reg_addr_t wa;
  word_t     wd;

  // Read enables and the branch flag are not needed by this slice
  decoder u_decoder (
    .instr   (instr),
    .imm     (imm),
    .raddr1  (raddr1),
    .raddr2  (raddr2),
    .waddr   (waddr),
    .wren    (wren),
    .rden1   (),
    .rden2   (),
    .lui     (lui),
    .auipc   (auipc),
    .jal     (jal),
    .jalr    (jalr),
    .branch  (),
    .use_imm (use_imm),
    .alu_op  (alu_op),
    .bcu_op  (bcu_op),
    .valid   (valid)
  );

  register_file u_register_file (
    .clock  (clock),
    .rst    (rst),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .we     (we),
    .wa     (wa),
    .wd     (wd),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  alu u_alu (
    .alu_op (alu_op),
    .a      (rdata1),
    .b      (alu_b),
    .result (alu_result)
  );

  branch_unit u_branch_unit (
    .bcu_op (bcu_op),
    .jal    (jal),
    .jalr   (jalr),
    .pc     (pc),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .imm    (imm),
    .taken  (taken),
    .target (target)
  );

  writeback_stage u_writeback_stage (
    .clock          (clock),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .valid          (valid),
    .wren           (wren),
    .lui            (lui),
    .auipc          (auipc),
    .jal            (jal),
    .jalr           (jalr),
    .use_imm        (use_imm),
    .imm            (imm),
    .rdata2         (rdata2),
    .alu_result     (alu_result),
    .taken          (taken),
    .target         (target),
    .waddr          (waddr),
    .alu_b          (alu_b),
    .pc             (pc),
    .we             (we),
    .wa             (wa),
    .wd             (wd),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal),
    .retire_wren    (retire_wren),
    .retire_rd      (retire_rd),
    .retire_result  (retire_result),
    .retire_pc      (retire_pc),
    .next_pc        (next_pc)
  );

endmodule

`default_nettype wire

//--- hw/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
  import core_pkg::*;
(
  input  logic      clock,
  input  logic      rst,
  input  logic      instr_valid,
  input  logic      valid,
  input  logic      wren,
  input  logic      lui,
  input  logic      auipc,
  input  logic      jal,
  input  logic      jalr,
  input  logic      use_imm,
  input  word_t     imm,
  input  word_t     rdata2,
  input  word_t     alu_result,
  input  logic      taken,
  input  word_t     target,
  input  reg_addr_t waddr,
  output word_t     alu_b,
  output word_t     pc,
  output logic      we,
  output reg_addr_t wa,
  output word_t     wd,
  output logic      retire_valid,
  output logic      retire_illegal,
  output logic      retire_wren,
  output reg_addr_t retire_rd,
  output word_t     retire_result,
  output word_t     retire_pc,
  output word_t     next_pc
);

  word_t pc_incr;
  word_t pc_update;

  assign pc_incr = pc + 32'd4;

  // Illegal instructions fall through to pc + 4 even if flagged as a jump
  assign pc_update = (taken && valid) ? target : pc_incr;

  assign alu_b = use_imm ? imm : rdata2;

  always_comb begin
    if (lui) wd = imm;
    else if (auipc) wd = pc + imm;
    else if (jal || jalr) wd = pc_incr;
    else wd = alu_result;
  end

  assign we = instr_valid & valid & wren;
  assign wa = waddr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // PC and retire record
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= '0;
      retire_valid <= 1'b0;
      retire_illegal <= 1'b0;
      retire_wren <= 1'b0;
    end else begin
      retire_valid <= instr_valid;
      retire_illegal <= instr_valid & ~valid;
      retire_wren <= we;
      if (instr_valid) begin
        pc <= pc_update;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (instr_valid) begin
      retire_rd <= waddr;
      retire_result <= wd;
      retire_pc <= pc;
    end
  end

  // The PC register already holds the successor once the record is out
  assign next_pc = pc;

endmodule

`default_nettype wire

//--- hw/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit
  import core_pkg::*;
(
  input  bcu_op_t bcu_op,
  input  logic    jal,
  input  logic    jalr,
  input  word_t   pc,
  input  word_t   rdata1,
  input  word_t   rdata2,
  input  word_t   imm,
  output logic    taken,
  output word_t   target
);

  logic  cond;
  word_t jalr_sum;

  always_comb begin
    case (bcu_op)
      beq:     cond = (rdata1 == rdata2);
      bne:     cond = (rdata1 != rdata2);
      blt:     cond = ($signed(rdata1) < $signed(rdata2));
      bge:     cond = ($signed(rdata1) >= $signed(rdata2));
      bltu:    cond = (rdata1 < rdata2);
      bgeu:    cond = (rdata1 >= rdata2);
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = rdata1 + imm;

  assign taken = jal | jalr | cond;

  // jalr drops bit zero of the sum
  assign target = jalr ? {jalr_sum[31:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
  import core_pkg::*;
(
  input  alu_op_t alu_op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      alu_sltu: result = {31'b0, a < b};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
  import core_pkg::*;
(
  input  logic      clock,
  input  logic      rst,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  input  logic      we,
  input  reg_addr_t wa,
  input  word_t     wd,
  output word_t     rdata1,
  output word_t     rdata2
);

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // x0 is hard wired to zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hw/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder
  import core_pkg::*;
(
  input  instr_t    instr,
  output word_t     imm,
  output reg_addr_t raddr1,
  output reg_addr_t raddr2,
  output reg_addr_t waddr,
  output logic      wren,
  output logic      rden1,
  output logic      rden2,
  output logic      lui,
  output logic      auipc,
  output logic      jal,
  output logic      jalr,
  output logic      branch,
  output logic      use_imm,
  output alu_op_t   alu_op,
  output bcu_op_t   bcu_op,
  output logic      valid
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  logic    nonzero_waddr;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign waddr = instr[11:7];
  assign nonzero_waddr = |waddr;

  // Unused source fields read as x0
  assign raddr1 = rden1 ? instr[19:15] : '0;
  assign raddr2 = rden2 ? instr[24:20] : '0;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm = '0;
    wren = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    lui = 1'b0;
    auipc = 1'b0;
    jal = 1'b0;
    jalr = 1'b0;
    branch = 1'b0;
    use_imm = 1'b0;
    alu_op = alu_nop;
    bcu_op = bcu_none;
    valid = 1'b1;

    case (opcode)
      opcode_lui: begin
        imm = imm_u;
        wren = nonzero_waddr;
        lui = 1'b1;
      end
      opcode_auipc: begin
        imm = imm_u;
        wren = nonzero_waddr;
        auipc = 1'b1;
      end
      opcode_jal: begin
        imm = imm_j;
        wren = nonzero_waddr;
        jal = 1'b1;
      end
      opcode_jalr: begin
        imm = imm_i;
        wren = nonzero_waddr;
        rden1 = 1'b1;
        jalr = 1'b1;
        if (funct3 != 3'b000) valid = 1'b0;
      end
      opcode_branch: begin
        imm = imm_b;
        rden1 = 1'b1;
        rden2 = 1'b1;
        branch = 1'b1;
        case (funct3)
          funct_beq:  bcu_op = beq;
          funct_bne:  bcu_op = bne;
          funct_blt:  bcu_op = blt;
          funct_bge:  bcu_op = bge;
          funct_bltu: bcu_op = bltu;
          funct_bgeu: bcu_op = bgeu;
          default:    valid = 1'b0;
        endcase
      end
      // No memory here so loads and stores never write a register
      opcode_load: begin
        imm = imm_i;
        rden1 = 1'b1;
        if (!(funct3 inside {funct_lb, funct_lh, funct_lw, funct_lbu, funct_lhu})) begin
          valid = 1'b0;
        end
      end
      opcode_store: begin
        imm = imm_s;
        rden1 = 1'b1;
        rden2 = 1'b1;
        if (!(funct3 inside {funct_sb, funct_sh, funct_sw})) begin
          valid = 1'b0;
        end
      end
      opcode_immediate: begin
        imm = imm_i;
        wren = nonzero_waddr;
        rden1 = 1'b1;
        use_imm = 1'b1;
        case (funct3)
          funct_add:  alu_op = alu_add;
          funct_slt:  alu_op = alu_slt;
          funct_sltu: alu_op = alu_sltu;
          funct_xor:  alu_op = alu_xor;
          funct_or:   alu_op = alu_or;
          funct_and:  alu_op = alu_and;
          funct_sll: begin
            if (funct7 == funct7_base) alu_op = alu_sll;
            else valid = 1'b0;
          end
          funct_srl: begin
            if (funct7 == funct7_base) alu_op = alu_srl;
            else if (funct7 == funct7_alt) alu_op = alu_sra;
            else valid = 1'b0;
          end
        endcase
      end
      opcode_register: begin
        wren = nonzero_waddr;
        rden1 = 1'b1;
        rden2 = 1'b1;
        if (funct7 == funct7_base) begin
          case (funct3)
            funct_add:  alu_op = alu_add;
            funct_sll:  alu_op = alu_sll;
            funct_slt:  alu_op = alu_slt;
            funct_sltu: alu_op = alu_sltu;
            funct_xor:  alu_op = alu_xor;
            funct_srl:  alu_op = alu_srl;
            funct_or:   alu_op = alu_or;
            funct_and:  alu_op = alu_and;
          endcase
        end else if (funct7 == funct7_alt) begin
          case (funct3)
            funct_add: alu_op = alu_sub;
            funct_srl: alu_op = alu_sra;
            default:   valid = 1'b0;
          endcase
        end else begin
          valid = 1'b0;
        end
      end
      // System, fence and anything else retire as illegal
      default: valid = 1'b0;
    endcase

    if (instr == nop_instr) begin
      alu_op = alu_nop;
    end
  end

endmodule

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths and vector types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;
  localparam int opcode_width = 7;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [opcode_width-1:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Opcodes and function codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam opcode_t opcode_lui       = 7'b0110111;
  localparam opcode_t opcode_auipc     = 7'b0010111;
  localparam opcode_t opcode_jal       = 7'b1101111;
  localparam opcode_t opcode_jalr      = 7'b1100111;
  localparam opcode_t opcode_branch    = 7'b1100011;
  localparam opcode_t opcode_load      = 7'b0000011;
  localparam opcode_t opcode_store     = 7'b0100011;
  localparam opcode_t opcode_immediate = 7'b0010011;
  localparam opcode_t opcode_register  = 7'b0110011;

  localparam funct3_t funct_add  = 3'b000;
  localparam funct3_t funct_sll  = 3'b001;
  localparam funct3_t funct_slt  = 3'b010;
  localparam funct3_t funct_sltu = 3'b011;
  localparam funct3_t funct_xor  = 3'b100;
  localparam funct3_t funct_srl  = 3'b101;
  localparam funct3_t funct_or   = 3'b110;
  localparam funct3_t funct_and  = 3'b111;

  localparam funct3_t funct_beq  = 3'b000;
  localparam funct3_t funct_bne  = 3'b001;
  localparam funct3_t funct_blt  = 3'b100;
  localparam funct3_t funct_bge  = 3'b101;
  localparam funct3_t funct_bltu = 3'b110;
  localparam funct3_t funct_bgeu = 3'b111;

  // Load and store widths are only checked for legality
  localparam funct3_t funct_lb  = 3'b000;
  localparam funct3_t funct_lh  = 3'b001;
  localparam funct3_t funct_lw  = 3'b010;
  localparam funct3_t funct_lbu = 3'b100;
  localparam funct3_t funct_lhu = 3'b101;
  localparam funct3_t funct_sb  = 3'b000;
  localparam funct3_t funct_sh  = 3'b001;
  localparam funct3_t funct_sw  = 3'b010;

  localparam funct7_t funct7_base = 7'b0000000;
  localparam funct7_t funct7_alt  = 7'b0100000;

  // addi x0,x0,0
  localparam instr_t nop_instr = 32'h00000013;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operation selects
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [3:0] {
    alu_nop, alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    bcu_none, beq, bne, blt, bge, bltu, bgeu
  } bcu_op_t;

endpackage

`default_nettype wire
